// File: Bender.yml
package:
  name: ex_lane

sources:
  - files:
      - design/exPkg.sv
      - design/fpuConvS2D.sv
      - design/fpuConvH2D.sv
      - design/ex1Stage.sv
      - design/ex2Stage.sv
      - design/ex3Stage.sv
      - design/exLane.sv
  - target: test
    files:
      - test/exLane_assertions.sv
      - test/exLaneTb.sv

// File: design/ex1Stage.sv
// ##########################################################
// EX1, ALU and address generation
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module ex1Stage (
	input wire clock,
	input wire reset,
	input wire hold,                               // lane stall from EX3
	input wire issueValid,
	input wire exPkg::microOp_t opCode,
	input wire exPkg::convSel_t convMode,
	input wire [exPkg::dataWidth-1:0] valueRs,
	input wire [exPkg::dataWidth-1:0] valueRt,
	input wire [exPkg::dataWidth-1:0] valueRm,
	input wire [exPkg::immWidth-1:0] immediate,
	input wire [exPkg::regIdWidth-1:0] destId,
	output exPkg::microOp_t ex1Op,
	output exPkg::convSel_t ex1Conv,
	output logic [exPkg::regIdWidth-1:0] ex1DestId,
	output logic [exPkg::dataWidth-1:0] ex1Result,
	output logic [exPkg::dataWidth-1:0] ex1ValueRs,
	output logic [exPkg::dataWidth-1:0] ex1ValueRt,
	output logic [exPkg::dataWidth-1:0] memAddr,
	output logic memRead,
	output logic memWrite,
	output logic [exPkg::dataWidth-1:0] memWriteData
);

	logic [exPkg::dataWidth-1:0] ex1ValueRm;   // store data
	logic [exPkg::immWidth-1:0] ex1Imm;
	logic [exPkg::dataWidth-1:0] immExt;
	logic [exPkg::dataWidth-1:0] effAddr;

	// op register, a nop when nothing issued
	always_ff @(posedge clock) begin
		if (reset) begin
			ex1Op <= exPkg::opNop;
		end else if (!hold) begin
			ex1Op <= issueValid ? opCode : exPkg::opNop;
		end
	end

	// operands and dest
	always_ff @(posedge clock) begin
		if (!hold) begin
			ex1Conv <= convMode;
			ex1DestId <= issueValid ? destId : exPkg::zeroRegId;
			ex1ValueRs <= valueRs;
			ex1ValueRt <= valueRt;
			ex1ValueRm <= valueRm;
			ex1Imm <= immediate;
		end
	end

	// base plus sign-extended displacement
	assign immExt = {{(exPkg::dataWidth-exPkg::immWidth){ex1Imm[exPkg::immWidth-1]}}, ex1Imm};
	assign effAddr = ex1ValueRs + immExt;

	always_comb begin
		case (ex1Op)
			exPkg::opAdd: ex1Result = ex1ValueRs + ex1ValueRt;
			exPkg::opSub: ex1Result = ex1ValueRs - ex1ValueRt;
			default: ex1Result = effAddr;   // lea style, unused by mem ops
		endcase
	end

	// request strobes, stay up while held
	assign memAddr = effAddr;
	assign memRead = (ex1Op == exPkg::opLoad) || (ex1Op == exPkg::opLoadFp);
	assign memWrite = (ex1Op == exPkg::opStore);
	assign memWriteData = ex1ValueRm;

endmodule

`default_nettype wire

// File: design/ex2Stage.sv
// ##########################################################
// EX2, multiply stage
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module ex2Stage (
	input wire clock,
	input wire reset,
	input wire hold,
	input wire exPkg::microOp_t ex1Op,
	input wire exPkg::convSel_t ex1Conv,
	input wire [exPkg::regIdWidth-1:0] ex1DestId,
	input wire [exPkg::dataWidth-1:0] ex1Result,
	input wire [exPkg::dataWidth-1:0] ex1ValueRs,
	input wire [exPkg::dataWidth-1:0] ex1ValueRt,
	output exPkg::microOp_t ex2Op,
	output exPkg::convSel_t ex2Conv,
	output logic [exPkg::regIdWidth-1:0] ex2DestId,
	output logic [exPkg::dataWidth-1:0] ex2Result
);

	logic [exPkg::dataWidth-1:0] aluResult;   // EX1 result held here
	logic [exPkg::dataWidth-1:0] mulOpA;
	logic [exPkg::dataWidth-1:0] mulOpB;
	logic [exPkg::dataWidth-1:0] mulLow;

	always_ff @(posedge clock) begin
		if (reset) begin
			ex2Op <= exPkg::opNop;
		end else if (!hold) begin
			ex2Op <= ex1Op;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			ex2Conv <= ex1Conv;
			ex2DestId <= ex1DestId;
			aluResult <= ex1Result;
			mulOpA <= ex1ValueRs;
			mulOpB <= ex1ValueRt;
		end
	end

	// low half only, signedness does not matter here
	assign mulLow = mulOpA * mulOpB;

	always_comb begin
		ex2Result = aluResult;   // forward by default
		if (ex2Op == exPkg::opMul) begin
			ex2Result = mulLow;
		end
	end

endmodule

`default_nettype wire

// File: design/ex3Stage.sv
// ##########################################################
// EX3, result select and writeback
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module ex3Stage (
	input wire clock,
	input wire reset,
	input wire exPkg::microOp_t ex2Op,
	input wire exPkg::convSel_t ex2Conv,
	input wire [exPkg::regIdWidth-1:0] ex2DestId,
	input wire [exPkg::dataWidth-1:0] ex2Result,
	input wire branchFlush,                          // kills the op in EX3
	input wire [exPkg::dataWidth-1:0] memDataIn,
	input wire exPkg::memStatus_t memStatus,
	input wire [exPkg::dataWidth-1:0] convSingleValue,
	input wire [exPkg::dataWidth-1:0] convHalfValue,
	output logic laneHold,
	output logic [exPkg::regIdWidth-1:0] forwardId,
	output logic [exPkg::dataWidth-1:0] forwardValue,
	output logic [exPkg::regIdWidth-1:0] writebackId,
	output logic [exPkg::dataWidth-1:0] writebackValue,
	output logic memFaultPulse
);

	exPkg::microOp_t ex3Op;
	exPkg::convSel_t ex3Conv;
	logic [exPkg::regIdWidth-1:0] ex3DestId;
	logic [exPkg::dataWidth-1:0] ex3Result;
	logic isMemOp;    // load or store sitting in EX3
	logic doOut;      // op has a destination
	logic squash;

	// stage register, frozen while memory holds
	always_ff @(posedge clock) begin
		if (reset) begin
			ex3Op <= exPkg::opNop;
		end else if (!laneHold) begin
			ex3Op <= ex2Op;
		end
	end

	always_ff @(posedge clock) begin
		if (!laneHold) begin
			ex3Conv <= ex2Conv;
			ex3DestId <= ex2DestId;
			ex3Result <= ex2Result;
		end
	end

	// status is only looked at for memory ops
	assign isMemOp = (ex3Op == exPkg::opLoad) || (ex3Op == exPkg::opLoadFp) ||
		(ex3Op == exPkg::opStore);
	assign laneHold = isMemOp && (memStatus == exPkg::memHold);
	assign memFaultPulse = isMemOp && (memStatus == exPkg::memFault);

	// result select
	always_comb begin
		forwardValue = ex3Result;   // alu or product by default
		doOut = 1'b1;
		case (ex3Op)
			exPkg::opNop, exPkg::opStore: begin
				doOut = 1'b0;
			end
			exPkg::opLoad: begin
				forwardValue = memDataIn;   // raw
			end
			exPkg::opLoadFp: begin
				case (ex3Conv)
					exPkg::convSingle: forwardValue = convSingleValue;
					exPkg::convHalf: forwardValue = convHalfValue;
					default: forwardValue = memDataIn;
				endcase
			end
			default: begin
			end
		endcase
	end

	// fault, flush and hold all drop the write, data not valid under hold
	assign squash = branchFlush || memFaultPulse || laneHold;
	assign forwardId = (doOut && !squash) ? ex3DestId : exPkg::zeroRegId;

	always_ff @(posedge clock) begin
		if (reset) begin
			writebackId <= exPkg::zeroRegId;
		end else begin
			writebackId <= forwardId;
		end
	end

	always_ff @(posedge clock) begin
		writebackValue <= forwardValue;
	end

endmodule

`default_nettype wire

// File: design/exLane.sv
// ##########################################################
// three stage execute lane
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module exLane (
	input wire clock,
	input wire reset,
	input wire issueValid,
	input wire exPkg::microOp_t opCode,
	input wire exPkg::convSel_t convMode,
	input wire [exPkg::dataWidth-1:0] valueRs,
	input wire [exPkg::dataWidth-1:0] valueRt,
	input wire [exPkg::dataWidth-1:0] valueRm,
	input wire [exPkg::immWidth-1:0] immediate,
	input wire [exPkg::regIdWidth-1:0] destId,
	input wire branchFlush,
	output logic [exPkg::dataWidth-1:0] memAddr,
	output logic memRead,
	output logic memWrite,
	output logic [exPkg::dataWidth-1:0] memWriteData,
	input wire [exPkg::dataWidth-1:0] memDataIn,   // aligned with EX3
	input wire exPkg::memStatus_t memStatus,
	output logic laneHold,
	output logic [exPkg::regIdWidth-1:0] forwardId,
	output logic [exPkg::dataWidth-1:0] forwardValue,
	output logic [exPkg::regIdWidth-1:0] writebackId,
	output logic [exPkg::dataWidth-1:0] writebackValue,
	output logic memFaultPulse
);

	wire exPkg::microOp_t ex1Op;
	wire exPkg::convSel_t ex1Conv;
	wire [exPkg::regIdWidth-1:0] ex1DestId;
	wire [exPkg::dataWidth-1:0] ex1Result;
	wire [exPkg::dataWidth-1:0] ex1ValueRs;
	wire [exPkg::dataWidth-1:0] ex1ValueRt;
	wire exPkg::microOp_t ex2Op;
	wire exPkg::convSel_t ex2Conv;
	wire [exPkg::regIdWidth-1:0] ex2DestId;
	wire [exPkg::dataWidth-1:0] ex2Result;
	wire [exPkg::dataWidth-1:0] convSingleValue;   // widened load data
	wire [exPkg::dataWidth-1:0] convHalfValue;

	ex1Stage ex1 (
		.clock(clock), .reset(reset), .hold(laneHold),
		.issueValid(issueValid), .opCode(opCode), .convMode(convMode),
		.valueRs(valueRs), .valueRt(valueRt), .valueRm(valueRm),
		.immediate(immediate), .destId(destId),
		.ex1Op(ex1Op), .ex1Conv(ex1Conv), .ex1DestId(ex1DestId),
		.ex1Result(ex1Result), .ex1ValueRs(ex1ValueRs), .ex1ValueRt(ex1ValueRt),
		.memAddr(memAddr), .memRead(memRead), .memWrite(memWrite),
		.memWriteData(memWriteData)
	);

	ex2Stage ex2 (
		.clock(clock), .reset(reset), .hold(laneHold),
		.ex1Op(ex1Op), .ex1Conv(ex1Conv), .ex1DestId(ex1DestId),
		.ex1Result(ex1Result), .ex1ValueRs(ex1ValueRs), .ex1ValueRt(ex1ValueRt),
		.ex2Op(ex2Op), .ex2Conv(ex2Conv), .ex2DestId(ex2DestId),
		.ex2Result(ex2Result)
	);

	// converters work on the incoming load data
	fpuConvS2D convS2D (.single(memDataIn[31:0]), .double(convSingleValue));
	fpuConvH2D convH2D (.half(memDataIn[15:0]), .double(convHalfValue));

	ex3Stage ex3 (
		.clock(clock), .reset(reset),
		.ex2Op(ex2Op), .ex2Conv(ex2Conv), .ex2DestId(ex2DestId),
		.ex2Result(ex2Result), .branchFlush(branchFlush),
		.memDataIn(memDataIn), .memStatus(memStatus),
		.convSingleValue(convSingleValue), .convHalfValue(convHalfValue),
		.laneHold(laneHold), .forwardId(forwardId), .forwardValue(forwardValue),
		.writebackId(writebackId), .writebackValue(writebackValue),
		.memFaultPulse(memFaultPulse)
	);

endmodule

`default_nettype wire

// File: design/exPkg.sv
// ##########################################################
// execute lane shared types
// ##########################################################
`default_nettype none

package exPkg;

	// datapath widths
	localparam int dataWidth = 64;   // register value
	localparam int regIdWidth = 6;   // register id
	localparam int immWidth = 33;    // decoder immediate, signed

	// id 0 is the null destination, no write
	localparam logic [regIdWidth-1:0] zeroRegId = '0;

	// micro-ops handled by this lane
	typedef enum logic [2:0] {
		opNop    = 3'd0,
		opAdd    = 3'd1,
		opSub    = 3'd2,
		opMul    = 3'd3,
		opLoad   = 3'd4,   // 64-bit raw
		opLoadFp = 3'd5,   // load then widen to double
		opStore  = 3'd6
	} microOp_t;

	// load conversion select for opLoadFp
	typedef enum logic [1:0] {
		convSingle = 2'd0,   // bits 31:0
		convHalf   = 2'd1,   // bits 15:0
		convRaw    = 2'd2    // as loaded
	} convSel_t;

	// memory status level, bit 1 is busy
	typedef enum logic [1:0] {
		memReady = 2'b00,
		memHold  = 2'b10,
		memFault = 2'b11
	} memStatus_t;

endpackage

`default_nettype wire

// File: design/fpuConvH2D.sv
// ##########################################################
// half to double widening
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module fpuConvH2D (
	input wire [15:0] half,
	output logic [63:0] double
);

	logic sgn;
	logic [4:0] expIn;
	logic [9:0] fracIn;
	logic [10:0] expOut;

	assign sgn = half[15];
	assign expIn = half[14:10];
	assign fracIn = half[9:0];

	// bias 15 -> 1023
	assign expOut = {6'b000000, expIn} + 11'd1008;

	always_comb begin
		case (expIn)
			5'h00: begin
				double = {sgn, 63'b0};   // signed zero, no denormals
			end
			5'h1F: begin
				// exp 31 maps to 2047, nan payload kept in top bits
				double = {sgn, 11'h7FF, fracIn, 42'b0};
			end
			default: begin
				double = {sgn, expOut, fracIn, 42'b0};
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/fpuConvS2D.sv
// ##########################################################
// single to double widening
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module fpuConvS2D (
	input wire [31:0] single,
	output logic [63:0] double
);

	logic sgn;
	logic [7:0] expIn;
	logic [22:0] fracIn;
	logic [10:0] expOut;

	assign sgn = single[31];
	assign expIn = single[30:23];
	assign fracIn = single[22:0];

	// bias 127 -> 1023
	assign expOut = {3'b000, expIn} + 11'd896;

	always_comb begin
		case (expIn)
			8'h00: begin
				// zero, denormals flushed to zero
				double = {sgn, 63'b0};
			end
			8'hFF: begin
				// inf or nan, payload goes to the top of the fraction
				double = {sgn, 11'h7FF, fracIn, 29'b0};
			end
			default: begin
				double = {sgn, expOut, fracIn, 29'b0};
			end
		endcase
	end

endmodule

`default_nettype wire

// File: exLane.f
design/exPkg.sv
design/fpuConvS2D.sv
design/fpuConvH2D.sv
design/ex1Stage.sv
design/ex2Stage.sv
design/ex3Stage.sv
design/exLane.sv
test/exLane_assertions.sv
test/exLaneTb.sv

// File: test/exLaneTb.sv
// ##########################################################
// execute lane testbench
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module exLaneTb;

	localparam int numCycles = 800;
	localparam int drainLimit = 40;   // cycles allowed to empty the lane

	logic clock;
	logic reset;
	logic issueValid;
	exPkg::microOp_t opCode;
	exPkg::convSel_t convMode;
	logic [exPkg::dataWidth-1:0] valueRs;
	logic [exPkg::dataWidth-1:0] valueRt;
	logic [exPkg::dataWidth-1:0] valueRm;
	logic [exPkg::immWidth-1:0] immediate;
	logic [exPkg::regIdWidth-1:0] destId;
	logic branchFlush;
	logic [exPkg::dataWidth-1:0] memDataIn;
	exPkg::memStatus_t memStatus;
	wire [exPkg::dataWidth-1:0] memAddr;
	wire memRead;
	wire memWrite;
	wire [exPkg::dataWidth-1:0] memWriteData;
	wire laneHold;
	wire [exPkg::regIdWidth-1:0] forwardId;
	wire [exPkg::dataWidth-1:0] forwardValue;
	wire [exPkg::regIdWidth-1:0] writebackId;
	wire [exPkg::dataWidth-1:0] writebackValue;
	wire memFaultPulse;

	// shadow pipeline index 1..3 is EX1..EX3
	exPkg::microOp_t stOp [1:3];
	exPkg::convSel_t stConv [1:3];
	logic [exPkg::regIdWidth-1:0] stDest [1:3];
	logic [63:0] stAlu [1:3];    // add, sub or mul result
	logic [63:0] stAddr [1:3];
	logic [63:0] stData [1:3];   // store data
	logic [63:0] mem [0:15];     // memory model
	logic [31:0] rngState;
	logic prevHold;              // issue inputs must stay
	int holdRun;
	logic [exPkg::regIdWidth-1:0] wbExpId;
	logic [63:0] wbExpVal;
	int errors;
	int checks;
	int timeouts;

	exLane dut0 (
		.clock(clock), .reset(reset), .issueValid(issueValid), .opCode(opCode),
		.convMode(convMode), .valueRs(valueRs), .valueRt(valueRt), .valueRm(valueRm),
		.immediate(immediate), .destId(destId), .branchFlush(branchFlush),
		.memAddr(memAddr), .memRead(memRead), .memWrite(memWrite),
		.memWriteData(memWriteData), .memDataIn(memDataIn), .memStatus(memStatus),
		.laneHold(laneHold), .forwardId(forwardId), .forwardValue(forwardValue),
		.writebackId(writebackId), .writebackValue(writebackValue),
		.memFaultPulse(memFaultPulse)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	task automatic compareValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s at %0t: expected %h, actual %h", name, $time, expected, actual);
		end
	endtask

	function automatic bit isLoadOp(input exPkg::microOp_t op);
		return (op == exPkg::opLoad) || (op == exPkg::opLoadFp);
	endfunction

	function automatic bit isMemOp(input exPkg::microOp_t op);
		return isLoadOp(op) || (op == exPkg::opStore);
	endfunction

	function automatic bit hasDest(input exPkg::microOp_t op);
		return (op != exPkg::opNop) && (op != exPkg::opStore);
	endfunction

	// IEEE widening with denormals flushed to signed zero
	function automatic logic [63:0] widenSingle(input logic [31:0] s);
		int e;
		logic [10:0] ed;
		e = s[30:23];
		if (e == 0) return {s[31], 63'd0};
		ed = (e == 255) ? 11'h7ff : 11'(e - 127 + 1023);
		return {s[31], ed, s[22:0], 29'd0};
	endfunction

	function automatic logic [63:0] widenHalf(input logic [15:0] h);
		int e;
		logic [10:0] ed;
		e = h[14:10];
		if (e == 0) return {h[15], 63'd0};
		ed = (e == 31) ? 11'h7ff : 11'(e - 15 + 1023);
		return {h[15], ed, h[9:0], 42'd0};
	endfunction

	function automatic logic [63:0] aluModel(input exPkg::microOp_t op,
		input logic [63:0] a, input logic [63:0] b);
		case (op)
			exPkg::opAdd: return a + b;
			exPkg::opSub: return a - b;
			exPkg::opMul: return a * b;   // low 64 bits
			default: return 64'd0;
		endcase
	endfunction

	// EX3 result for an op and the data on the memory bus
	function automatic logic [63:0] expectedResult(input exPkg::microOp_t op,
		input exPkg::convSel_t conv, input logic [63:0] alu, input logic [63:0] data);
		if (op == exPkg::opLoad) return data;
		if (op != exPkg::opLoadFp) return alu;
		if (conv == exPkg::convSingle) return widenSingle(data[31:0]);
		if (conv == exPkg::convHalf) return widenHalf(data[15:0]);
		return data;
	endfunction

	// pick[3:2] selects the format and pick[1:0] the special value
	function automatic logic [63:0] shapeData(input logic [63:0] raw, input logic [3:0] pick);
		logic [63:0] v;
		v = raw;
		if (pick[3:2] == 2'd1) begin
			v[30:23] = pick[1] ? 8'hff : 8'h00;
			if (pick[0]) v[0] = 1'b1;
			else v[22:0] = '0;
		end else if (pick[3:2] == 2'd2) begin
			v[14:10] = pick[1] ? 5'h1f : 5'h00;
			if (pick[0]) v[0] = 1'b1;
			else v[9:0] = '0;
		end
		return v;
	endfunction

	task automatic driveIssue(input bit allowIssue);
		logic [31:0] r;
		r = nextRand();
		issueValid = allowIssue && (r[2:0] != 3'd0);
		case (r[6:4])
			3'd0: opCode = exPkg::opNop;
			3'd1: opCode = exPkg::opAdd;
			3'd2: opCode = exPkg::opSub;
			3'd3: opCode = exPkg::opMul;
			3'd4: opCode = exPkg::opLoad;
			3'd6: opCode = exPkg::opStore;
			default: opCode = exPkg::opLoadFp;
		endcase
		case (r[9:8])
			2'd1: convMode = exPkg::convHalf;
			2'd2: convMode = exPkg::convRaw;
			default: convMode = exPkg::convSingle;
		endcase
		destId = r[15:10];
		valueRs = {nextRand(), nextRand()};
		valueRt = {nextRand(), nextRand()};
		valueRm = shapeData({nextRand(), nextRand()}, r[19:16]);
		immediate = {r[20], nextRand()};
	endtask

	// one clock cycle entered and left 2 ns after the rising edge
	task automatic runCycle(input bit allowIssue);
		logic [31:0] r;
		logic hold;
		logic fault;
		logic [exPkg::regIdWidth-1:0] expId;
		logic [63:0] expVal;
		compareValue("writeback id", wbExpId, writebackId);
		if (wbExpId != exPkg::zeroRegId) compareValue("writeback value", wbExpVal, writebackValue);
		r = nextRand();
		memDataIn = isLoadOp(stOp[3]) ? mem[stAddr[3][3:0]] : {nextRand(), nextRand()};
		if (r[3:0] == 4'd0) memStatus = exPkg::memFault;
		else if (r[3:0] < 4'd5 && holdRun < 4) memStatus = exPkg::memHold;
		else memStatus = exPkg::memReady;
		branchFlush = (r[7:5] == 3'd0);
		if (!prevHold) driveIssue(allowIssue);
		hold = isMemOp(stOp[3]) && (memStatus == exPkg::memHold);
		fault = isMemOp(stOp[3]) && (memStatus == exPkg::memFault);
		expId = (hasDest(stOp[3]) && !hold && !fault && !branchFlush) ? stDest[3]
			: exPkg::zeroRegId;
		expVal = expectedResult(stOp[3], stConv[3], stAlu[3], memDataIn);
		#18;   // comb outputs settled by the falling edge
		compareValue("lane hold", hold, laneHold);
		compareValue("fault pulse", fault, memFaultPulse);
		compareValue("forward id", expId, forwardId);
		if (expId != exPkg::zeroRegId) compareValue("forward value", expVal, forwardValue);
		compareValue("mem read", isLoadOp(stOp[1]), memRead);
		compareValue("mem write", stOp[1] == exPkg::opStore, memWrite);
		if (isMemOp(stOp[1])) compareValue("mem address", stAddr[1], memAddr);
		if (stOp[1] == exPkg::opStore) compareValue("store data", stData[1], memWriteData);
		wbExpId = expId;
		wbExpVal = expVal;
		holdRun = hold ? holdRun + 1 : 0;
		if (!hold) begin
			if (stOp[3] == exPkg::opStore && memStatus == exPkg::memReady)
				mem[stAddr[3][3:0]] = stData[3];
			for (int k = 3; k > 1; k--) begin
				stOp[k] = stOp[k-1];
				stConv[k] = stConv[k-1];
				stDest[k] = stDest[k-1];
				stAlu[k] = stAlu[k-1];
				stAddr[k] = stAddr[k-1];
				stData[k] = stData[k-1];
			end
			stOp[1] = issueValid ? opCode : exPkg::opNop;
			stConv[1] = convMode;
			stDest[1] = destId;
			stAlu[1] = aluModel(opCode, valueRs, valueRt);
			stAddr[1] = valueRs + {{31{immediate[32]}}, immediate};
			stData[1] = valueRm;
		end
		prevHold = hold;
		@(posedge clock);
		#2;
	endtask

	initial begin
		int waited;
		rngState = 32'h7bdf1d09;
		errors = 0;
		checks = 0;
		timeouts = 0;
		reset = 1'b1;
		issueValid = 1'b0;
		opCode = exPkg::opNop;
		convMode = exPkg::convRaw;
		valueRs = '0;
		valueRt = '0;
		valueRm = '0;
		immediate = '0;
		destId = exPkg::zeroRegId;
		branchFlush = 1'b0;
		memDataIn = '0;
		memStatus = exPkg::memReady;
		prevHold = 1'b0;
		holdRun = 0;
		wbExpId = exPkg::zeroRegId;
		wbExpVal = '0;
		for (int i = 0; i < 16; i++) mem[i] = {16{i[3:0]}} ^ 64'h3ff0_0000_4049_0fdb;
		for (int k = 1; k <= 3; k++) begin
			stOp[k] = exPkg::opNop;
			stConv[k] = exPkg::convRaw;
			stDest[k] = exPkg::zeroRegId;
			stAlu[k] = '0;
			stAddr[k] = '0;
			stData[k] = '0;
		end
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;
		repeat (numCycles) runCycle(1'b1);
		// stop issuing and let the lane empty
		waited = 0;
		while ((issueValid || stOp[1] != exPkg::opNop || stOp[2] != exPkg::opNop ||
			stOp[3] != exPkg::opNop) && waited < drainLimit) begin
			runCycle(1'b0);
			waited++;
		end
		if (waited >= drainLimit) begin
			timeouts++;
			$display("timeout: lane did not drain within %0d cycles", drainLimit);
		end
		runCycle(1'b0);   // last writeback
		$display("%0d errors, %0d timeouts, %0d assertion failures, %0d checks", errors,
			timeouts, dut0.laneChecks.failCount, checks);
		if (errors == 0 && timeouts == 0 && dut0.laneChecks.failCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/exLane_assertions.sv
// ##########################################################
// execute lane bound assertions
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module exLaneAssertions (
	input wire clock,
	input wire reset,
	input wire laneHold,
	input wire exPkg::memStatus_t memStatus,
	input wire memRead,
	input wire memWrite,
	input wire memFaultPulse,
	input wire [exPkg::regIdWidth-1:0] writebackId
);

	int failCount = 0;   // failed assertions so far

	// stall only comes from a busy memory
	holdNeedsStatus: assert property (@(posedge clock) disable iff (reset)
		laneHold |-> memStatus == exPkg::memHold)
		else begin
			$error("lane held without a memory hold status");
			failCount++;
		end

	// one request kind per op
	oneStrobe: assert property (@(posedge clock) disable iff (reset)
		!(memRead && memWrite))
		else begin
			$error("memory read and write requested together");
			failCount++;
		end

	// faulted op writes nothing
	faultDropsWrite: assert property (@(posedge clock) disable iff (reset)
		memFaultPulse |=> writebackId == exPkg::zeroRegId)
		else begin
			$error("writeback after a memory fault was not squashed");
			failCount++;
		end

endmodule

bind exLane exLaneAssertions laneChecks (
	.clock(clock), .reset(reset), .laneHold(laneHold), .memStatus(memStatus),
	.memRead(memRead), .memWrite(memWrite), .memFaultPulse(memFaultPulse),
	.writebackId(writebackId)
);

`default_nettype wire
